//--- hdl/cdb_pkg.sv
package cdb_pkg;

    // Datapath and register file widths
    parameter int DATA_W     = 32;
    parameter int REG_IDX_W  = 5;
    parameter int NUM_PREG   = 64;
    parameter int PREG_IDX_W = $clog2(NUM_PREG);

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [PREG_IDX_W-1:0] preg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // Issue from a reservation station
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        data_t     opa;
        data_t     opb;
        reg_idx_t  dest_reg_idx;
        preg_idx_t p_reg_idx;
    } issue_packet_t;

    // Finished result offered to the CDB
    typedef struct packed {
        reg_idx_t  dest_reg_idx;
        preg_idx_t p_reg_idx;
        data_t     result;
    } fu_packet_t;

    // One broadcast slot
    typedef struct packed {
        reg_idx_t  reg_idx;
        preg_idx_t p_reg_idx;
        data_t     reg_val;
        logic      valid;
    } cdb_packet_t;

endpackage

//--- hdl/psel_gen.sv
`timescale 1ns/10ps

module psel_gen #(
    parameter int WIDTH = 4,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    // Each row takes the lowest request left over by the rows before it
    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = req;
        for (int r = 0; r < REQS; r++) begin
            // Isolate the lowest set bit
            gnt_bus[r] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[r];
        end
    end

    always_comb begin
        gnt = '0;
        for (int r = 0; r < REQS; r++) begin
            gnt = gnt | gnt_bus[r];
        end
    end

    assign empty = ~|req;

    // Pure combinational block, so the checks are deferred ones
    always_comb begin
        assert final ((gnt & ~req) == '0)
            else $error("psel_gen: grant without a matching request");
    end

    always_comb begin
        for (int r = 0; r < REQS; r++) begin
            assert final ($onehot0(gnt_bus[r]))
                else $error("psel_gen: grant row %0d has more than one bit set", r);
        end
    end

endmodule

//--- hdl/alu_fu.sv
`timescale 1ns/10ps

module alu_fu import cdb_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  issue_packet_t issue,
    input  logic          stall,
    output logic          issue_ready,
    output logic          fu_done,
    output fu_packet_t    wr_data
);

    data_t alu_result;

    assign issue_ready = ~stall;

    always_comb begin
        case (issue.op)
            ALU_ADD: alu_result = issue.opa + issue.opb;
            ALU_SUB: alu_result = issue.opa - issue.opb;
            ALU_AND: alu_result = issue.opa & issue.opb;
            ALU_OR:  alu_result = issue.opa | issue.opb;
            ALU_XOR: alu_result = issue.opa ^ issue.opb;
            // Shift amount from low five bits only
            ALU_SLL: alu_result = issue.opa << issue.opb[4:0];
            ALU_SRL: alu_result = issue.opa >> issue.opb[4:0];
            ALU_SLT: alu_result = data_t'($signed(issue.opa) < $signed(issue.opb));
            default: alu_result = '0;
        endcase
    end

    // Done flag follows the issue valid unless the CDB holds us
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fu_done <= 1'b0;
        end else if (!stall) begin
            fu_done <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            wr_data.dest_reg_idx <= issue.dest_reg_idx;
            wr_data.p_reg_idx    <= issue.p_reg_idx;
            wr_data.result       <= alu_result;
        end
    end

    // A stalled result must reach the CDB unchanged
    a_hold_while_stalled: assert property (
        @(posedge clock) disable iff (!rst_n)
        stall |=> fu_done && $stable(wr_data)
    ) else $error("alu_fu: result changed while stalled");

endmodule

//--- hdl/mult_fu.sv
`timescale 1ns/10ps

module mult_fu import cdb_pkg::*; #(
    parameter int MULT_STAGES = 3
) (
    input  logic          clock,
    input  logic          rst_n,
    input  issue_packet_t issue,
    input  logic          stall,
    output logic          issue_ready,
    output logic          fu_done,
    output fu_packet_t    wr_data
);

    // Multiplier bits consumed per stage
    localparam int    CHUNK      = (DATA_W + MULT_STAGES - 1) / MULT_STAGES;
    localparam data_t CHUNK_MASK = data_t'((64'd1 << CHUNK) - 64'd1);

    typedef struct packed {
        logic      valid;
        reg_idx_t  dest_reg_idx;
        preg_idx_t p_reg_idx;
        data_t     a;
        data_t     b;
        data_t     sum;
    } stage_t;

    stage_t [MULT_STAGES-1:0] stage;

    // Partial product of one multiplier chunk shifted into place
    function automatic data_t partial(input data_t a, input data_t b, input int s);
        data_t chunk;
        chunk = (b >> (s * CHUNK)) & CHUNK_MASK;
        return (a * chunk) << (s * CHUNK);
    endfunction

    assign issue_ready = ~stall;

    // All stages advance together and the whole pipe freezes on stall
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int s = 0; s < MULT_STAGES; s++) begin
                stage[s].valid <= 1'b0;
            end
        end else if (!stall) begin
            stage[0].valid        <= issue.valid;
            stage[0].dest_reg_idx <= issue.dest_reg_idx;
            stage[0].p_reg_idx    <= issue.p_reg_idx;
            stage[0].a            <= issue.opa;
            stage[0].b            <= issue.opb;
            stage[0].sum          <= partial(issue.opa, issue.opb, 0);
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage[s].valid        <= stage[s-1].valid;
                stage[s].dest_reg_idx <= stage[s-1].dest_reg_idx;
                stage[s].p_reg_idx    <= stage[s-1].p_reg_idx;
                stage[s].a            <= stage[s-1].a;
                stage[s].b            <= stage[s-1].b;
                stage[s].sum          <= stage[s-1].sum
                                         + partial(stage[s-1].a, stage[s-1].b, s);
            end
        end
    end

    assign fu_done              = stage[MULT_STAGES-1].valid;
    assign wr_data.dest_reg_idx = stage[MULT_STAGES-1].dest_reg_idx;
    assign wr_data.p_reg_idx    = stage[MULT_STAGES-1].p_reg_idx;
    assign wr_data.result       = stage[MULT_STAGES-1].sum;

    // Ungranted product sits in the last stage until the CDB takes it
    a_last_stage_held: assert property (
        @(posedge clock) disable iff (!rst_n)
        stall |=> $stable(stage[MULT_STAGES-1])
    ) else $error("mult_fu: last stage changed while stalled");

endmodule

//--- hdl/cdb.sv
`timescale 1ns/10ps

module cdb import cdb_pkg::*; #(
    parameter int N      = 2,
    parameter int NUM_FU = 3
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic       [NUM_FU-1:0] fu_done,
    input  fu_packet_t [NUM_FU-1:0] wr_data,
    output cdb_packet_t [N-1:0]     entries,
    output logic       [NUM_FU-1:0] stall_sig
);

    logic [NUM_FU-1:0]         cdb_gnt;
    logic [N-1:0][NUM_FU-1:0]  cdb_gnt_bus;
    fu_packet_t [N-1:0]        sel_pkt;
    logic [N-1:0]              entry_valid;

    psel_gen #(
        .WIDTH (NUM_FU),
        .REQS  (N)
    ) u_arb (
        .req     (fu_done),
        .gnt     (cdb_gnt),
        .gnt_bus (cdb_gnt_bus),
        .empty   ()
    );

    // Only a finished unit that lost arbitration is held
    assign stall_sig = fu_done & ~cdb_gnt;

    // One-hot mux per slot
    always_comb begin
        for (int i = 0; i < N; i++) begin
            sel_pkt[i] = '0;
            for (int j = 0; j < NUM_FU; j++) begin
                if (cdb_gnt_bus[i][j]) begin
                    sel_pkt[i] = sel_pkt[i] | wr_data[j];
                end
            end
            // Slot valid comes from the grant, a zero result is still a result
            entry_valid[i] = |cdb_gnt_bus[i];
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            entries[i].reg_idx   = sel_pkt[i].dest_reg_idx;
            entries[i].p_reg_idx = sel_pkt[i].p_reg_idx;
            entries[i].reg_val   = sel_pkt[i].result;
            entries[i].valid     = entry_valid[i];
        end
    end

    // Units never hold the same tag at once
    for (genvar i = 0; i < N; i++) begin : g_tag_chk_i
        for (genvar j = i + 1; j < N; j++) begin : g_tag_chk_j
            a_unique_tag: assert property (
                @(posedge clock) disable iff (!rst_n)
                !(entry_valid[i] && entry_valid[j]
                  && entries[i].p_reg_idx == entries[j].p_reg_idx)
            ) else $error("cdb: tag %0d broadcast twice", entries[i].p_reg_idx);
        end
    end

    a_slot_count: assert property (
        @(posedge clock) disable iff (!rst_n)
        $countones(entry_valid) ==
            (($countones(fu_done) < N) ? $countones(fu_done) : N)
    ) else $error("cdb: valid entry count does not match requests");

endmodule

//--- hdl/ready_table.sv
`timescale 1ns/10ps

module ready_table import cdb_pkg::*; #(
    parameter int N = 2
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  cdb_packet_t [N-1:0]   entries,
    input  logic                  alloc_valid,
    input  preg_idx_t             alloc_preg,
    output logic [NUM_PREG-1:0]   preg_ready
);

    // Everything is ready out of reset, rename clears a bit on allocation
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            preg_ready <= '1;
        end else begin
            if (alloc_valid) begin
                preg_ready[alloc_preg] <= 1'b0;
            end
            for (int i = 0; i < N; i++) begin
                if (entries[i].valid) begin
                    preg_ready[entries[i].p_reg_idx] <= 1'b1;
                end
            end
        end
    end

    // A tag cannot be reallocated before its old value has been broadcast
    for (genvar i = 0; i < N; i++) begin : g_alloc_chk
        a_alloc_vs_bcast: assert property (
            @(posedge clock) disable iff (!rst_n)
            !(alloc_valid && entries[i].valid && entries[i].p_reg_idx == alloc_preg)
        ) else $error("ready_table: tag %0d allocated while broadcast", alloc_preg);
    end

endmodule

//--- hdl/exec_complete.sv
`timescale 1ns/10ps

module exec_complete import cdb_pkg::*; #(
    parameter  int N           = 2,
    parameter  int NUM_ALU     = 2,
    parameter  int NUM_MULT    = 1,
    parameter  int MULT_STAGES = 3,
    localparam int NUM_FU      = NUM_ALU + NUM_MULT
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  issue_packet_t [NUM_FU-1:0] issue,
    output logic          [NUM_FU-1:0] issue_ready,
    input  logic                       alloc_valid,
    input  preg_idx_t                  alloc_preg,
    output cdb_packet_t   [N-1:0]      entries,
    output logic          [NUM_PREG-1:0] preg_ready
);

    logic       [NUM_FU-1:0] fu_done;
    fu_packet_t [NUM_FU-1:0] wr_data;
    logic       [NUM_FU-1:0] stall_sig;

    // ALUs sit at the low unit indices
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu
        alu_fu u_alu (
            .clock       (clock),
            .rst_n       (rst_n),
            .issue       (issue[k]),
            .stall       (stall_sig[k]),
            .issue_ready (issue_ready[k]),
            .fu_done     (fu_done[k]),
            .wr_data     (wr_data[k])
        );
    end

    // Multipliers follow the ALUs
    for (genvar m = 0; m < NUM_MULT; m++) begin : g_mult
        mult_fu #(
            .MULT_STAGES (MULT_STAGES)
        ) u_mult (
            .clock       (clock),
            .rst_n       (rst_n),
            .issue       (issue[NUM_ALU+m]),
            .stall       (stall_sig[NUM_ALU+m]),
            .issue_ready (issue_ready[NUM_ALU+m]),
            .fu_done     (fu_done[NUM_ALU+m]),
            .wr_data     (wr_data[NUM_ALU+m])
        );
    end

    cdb #(
        .N      (N),
        .NUM_FU (NUM_FU)
    ) u_cdb (
        .clock     (clock),
        .rst_n     (rst_n),
        .fu_done   (fu_done),
        .wr_data   (wr_data),
        .entries   (entries),
        .stall_sig (stall_sig)
    );

    ready_table #(
        .N (N)
    ) u_ready_table (
        .clock       (clock),
        .rst_n       (rst_n),
        .entries     (entries),
        .alloc_valid (alloc_valid),
        .alloc_preg  (alloc_preg),
        .preg_ready  (preg_ready)
    );

endmodule

//--- tb/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

    // Released on a falling edge so the first active edge sees a clean rst_n
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

//--- tb/exec_complete_tb.sv
`timescale 1ns/10ps

module exec_complete_tb import cdb_pkg::*; ();

    localparam int N           = 2;
    localparam int NUM_ALU     = 2;
    localparam int NUM_MULT    = 1;
    localparam int MULT_STAGES = 3;
    localparam int NUM_FU      = NUM_ALU + NUM_MULT;
    localparam int MAX_CASES   = 32;
    localparam int RAND_OPS    = 300;
    localparam int DRAIN_LIMIT = MULT_STAGES + NUM_FU + 4;

    logic                       clock;
    logic                       rst_n;
    issue_packet_t [NUM_FU-1:0] issue;
    logic          [NUM_FU-1:0] issue_ready;
    logic                       alloc_valid;
    preg_idx_t                  alloc_preg;
    cdb_packet_t   [N-1:0]      entries;
    logic          [NUM_PREG-1:0] preg_ready;

    // Cases read from the data file
    logic [8*16-1:0] c_name [MAX_CASES];
    int              c_group [MAX_CASES];
    int              c_delay [MAX_CASES];
    int              c_unit [MAX_CASES];
    int              c_op [MAX_CASES];
    int              c_dest [MAX_CASES];
    int              c_tag [MAX_CASES];
    int              c_lat [MAX_CASES];
    data_t           c_opa [MAX_CASES];
    data_t           c_opb [MAX_CASES];
    data_t           c_exp [MAX_CASES];
    bit              c_issued [MAX_CASES];
    int              num_cases = 0;
    bit              cases_loaded = 1'b0;

    // Scoreboard, indexed by physical tag
    bit              pending [NUM_PREG];
    bit              sb_alloc [NUM_PREG];
    bit              sb_ready_due [NUM_PREG];
    data_t           sb_val [NUM_PREG];
    reg_idx_t        sb_dest [NUM_PREG];
    int              sb_unit [NUM_PREG];
    int              sb_lat [NUM_PREG];
    int              sb_cycle [NUM_PREG];
    logic [8*16-1:0] sb_name [NUM_PREG];

    int                outstanding = 0;
    int                cycle = 0;
    int                value_errs = 0;
    int                other_errs = 0;
    logic [31:0]       rng_state = 32'd68418;
    logic [NUM_FU-1:0] prev_ready;

    clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (2)
    ) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    exec_complete #(
        .N           (N),
        .NUM_ALU     (NUM_ALU),
        .NUM_MULT    (NUM_MULT),
        .MULT_STAGES (MULT_STAGES)
    ) dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_ready (issue_ready),
        .alloc_valid (alloc_valid),
        .alloc_preg  (alloc_preg),
        .entries     (entries),
        .preg_ready  (preg_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Opcode rules; the multiplier keeps the low word of the product
    function automatic data_t model_result(input bit is_mult, input alu_op_e op,
                                           input data_t a, input data_t b);
        if (is_mult)
            return a * b;
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input logic [8*16-1:0] name, input string what,
                               input data_t expected, input data_t actual);
        assert (expected == actual) else begin
            value_errs++;
            $display("ERR %0s %0s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            other_errs++;
            $display("%0s", msg);
        end
    endtask

    // Move to the falling edge and score what the DUT did in this cycle
    task automatic tick();
        preg_idx_t tag;
        int        lat;
        @(negedge clock);
        cycle++;
        for (int t = 0; t < NUM_PREG; t++) begin
            if (sb_ready_due[t]) begin
                check_true(preg_ready[t], $sformatf("Tag %0d not ready after its broadcast", t));
                sb_ready_due[t] = 1'b0;
                sb_alloc[t]     = 1'b0;
            end else if (sb_alloc[t]) begin
                check_true(!preg_ready[t], $sformatf("Tag %0d ready before its broadcast", t));
            end
        end
        for (int i = 0; i < N; i++) begin
            if (entries[i].valid) begin
                tag = entries[i].p_reg_idx;
                if (!pending[tag]) begin
                    check_true(1'b0, $sformatf("Tag %0d broadcast with nothing in flight", tag));
                end else begin
                    lat = cycle - sb_cycle[tag];
                    check_value(sb_name[tag], "value", sb_val[tag], entries[i].reg_val);
                    check_value(sb_name[tag], "dest", data_t'(sb_dest[tag]),
                                data_t'(entries[i].reg_idx));
                    if (sb_lat[tag] != 0) begin
                        check_value(sb_name[tag], "latency", data_t'(sb_lat[tag]), data_t'(lat));
                        // A late result means the unit was held by the CDB
                        if (lat > ((sb_unit[tag] < NUM_ALU) ? 1 : MULT_STAGES))
                            check_true(!prev_ready[sb_unit[tag]],
                                $sformatf("Unit %0d waited but kept issue_ready high",
                                          sb_unit[tag]));
                    end
                    pending[tag] = 1'b0;
                    outstanding--;
                    if (sb_alloc[tag])
                        sb_ready_due[tag] = 1'b1;
                end
            end
        end
        prev_ready  = issue_ready;
        issue       = '0;
        alloc_valid = 1'b0;
    endtask

    task automatic issue_op(input int k, input logic [8*16-1:0] name, input alu_op_e op,
                            input data_t a, input data_t b, input reg_idx_t dest,
                            input preg_idx_t tag, input int lat, input data_t expected);
        issue[k].valid        = 1'b1;
        issue[k].op           = op;
        issue[k].opa          = a;
        issue[k].opb          = b;
        issue[k].dest_reg_idx = dest;
        issue[k].p_reg_idx    = tag;
        pending[tag]  = 1'b1;
        sb_val[tag]   = expected;
        sb_dest[tag]  = dest;
        sb_unit[tag]  = k;
        sb_lat[tag]   = lat;
        sb_cycle[tag] = cycle;
        sb_name[tag]  = name;
        outstanding++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding > 0 && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        check_true(outstanding == 0, $sformatf("%0d tags were never broadcast", outstanding));
    endtask

    task automatic load_cases();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("tb/exec_cases.txt", "r");
        if (fd == 0) begin
            check_true(1'b0, "Cannot open tb/exec_cases.txt");
        end else begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %d %d %d %d %h %h %d %d %d %h",
                                  c_name[num_cases], c_group[num_cases], c_delay[num_cases],
                                  c_unit[num_cases], c_op[num_cases], c_opa[num_cases],
                                  c_opb[num_cases], c_dest[num_cases], c_tag[num_cases],
                                  c_lat[num_cases], c_exp[num_cases]);
                    if (cnt == 11)
                        num_cases++;
                end
            end
            $fclose(fd);
        end
        cases_loaded = 1'b1;
    endtask

    task automatic run_file_cases();
        int first;
        int last;
        int r;
        int left;
        first = 0;
        while (first < num_cases) begin
            last = first;
            while (last + 1 < num_cases && c_group[last+1] == c_group[first])
                last++;
            // Rename allocates the group's tags ahead of issue
            for (int c = first; c <= last; c++) begin
                tick();
                alloc_valid        = 1'b1;
                alloc_preg         = preg_idx_t'(c_tag[c]);
                sb_alloc[c_tag[c]] = 1'b1;
                c_issued[c]        = 1'b0;
            end
            left = last - first + 1;
            r    = 0;
            while (left > 0) begin
                tick();
                for (int c = first; c <= last; c++) begin
                    if (!c_issued[c] && c_delay[c] <= r && issue_ready[c_unit[c]]) begin
                        issue_op(c_unit[c], c_name[c], alu_op_e'(c_op[c][2:0]), c_opa[c],
                                 c_opb[c], reg_idx_t'(c_dest[c]), preg_idx_t'(c_tag[c]),
                                 c_lat[c], c_exp[c]);
                        c_issued[c] = 1'b1;
                        left--;
                    end
                end
                r++;
            end
            drain();
            first = last + 1;
        end
    endtask

    task automatic run_random(input int count);
        int        issued;
        preg_idx_t tag;
        alu_op_e   op;
        data_t     a;
        data_t     b;
        issued = 0;
        tag    = '0;
        while (issued < count) begin
            tick();
            for (int k = 0; k < NUM_FU; k++) begin
                tag = tag + 1'b1;
                if (issued < count && issue_ready[k] && !pending[tag] && !sb_alloc[tag]
                    && (rand_word() & 32'd3) != 0) begin
                    op = alu_op_e'(3'(rand_word()));
                    a  = rand_word();
                    b  = rand_word();
                    issue_op(k, "random", op, a, b, reg_idx_t'(rand_word()), tag, 0,
                             model_result(k >= NUM_ALU, op, a, b));
                    issued++;
                end
            end
        end
        drain();
    endtask

    initial begin
        issue       = '0;
        alloc_valid = 1'b0;
        alloc_preg  = '0;
        load_cases();
        wait (rst_n === 1'b1);
        tick();
        check_true(issue_ready == '1, "issue_ready not all high after reset");
        check_true(preg_ready == '1, "preg_ready not all set after reset");
        for (int i = 0; i < N; i++)
            check_true(!entries[i].valid, "CDB entry valid after reset");
        run_file_cases();
        run_random(RAND_OPS);
        tick();
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget scales with the number of operations
    initial begin
        wait (cases_loaded);
        repeat ((num_cases + RAND_OPS) * (MULT_STAGES + NUM_FU + 4)) @(posedge clock);
        $display("Watchdog expired, the DUT stopped broadcasting results");
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        $display("Test failed");
        $finish;
    end

endmodule

//--- all.f
hdl/cdb_pkg.sv
hdl/psel_gen.sv
hdl/alu_fu.sv
hdl/mult_fu.sv
hdl/cdb.sv
hdl/ready_table.sv
hdl/exec_complete.sv
tb/clock_gen.sv
tb/exec_complete_tb.sv

//--- tb/exec_cases.txt
# name group delay unit op opa opb dest tag latency expected
# op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt, unit 2 multiplies, values in hex
alu_add    0  0 0 0 00000005 00000007 1  1  1 0000000c
alu_sub    1  0 1 1 00000003 00000005 2  2  1 fffffffe
alu_and    2  0 0 2 f0f0ff00 0ff0f0ff 3  3  1 00f0f000
alu_or     3  0 1 3 f0000000 0000000f 4  4  1 f000000f
alu_xor    4  0 0 4 aaaa5555 ffff0000 5  5  1 55555555
alu_sll    5  0 1 5 00000001 00000024 6  6  1 00000010
alu_srl    6  0 0 6 80000000 0000001f 7  7  1 00000001
alu_slt    7  0 1 7 ffffffff 00000001 8  8  1 00000001
alu_slt_n  8  0 0 7 00000005 fffffffe 9  17 1 00000000
mul_one    9  0 2 0 00010003 00020005 9  9  3 000b000f
mul_b2b_a  10 0 2 0 00000007 00000006 10 10 3 0000002a
mul_b2b_b  10 1 2 0 ffffffff 00000002 11 11 3 fffffffe
mul_b2b_c  10 2 2 0 00001234 00000010 12 12 3 00012340
mul_cont   11 0 2 0 00000064 00000003 13 13 4 0000012c
alu0_cont  11 2 0 0 00000001 00000002 14 14 1 00000003
alu1_cont  11 2 1 1 00000000 00000001 15 15 1 ffffffff
alu_zero   12 0 0 4 12345678 12345678 16 16 1 00000000
alu_tag63  13 0 1 0 7fffffff 00000001 31 63 1 80000000
